/* probe_unit.f */
dcache_pkg.sv
probe_intake.sv
probe_queue.sv
probe_engine.sv
probe_unit.sv
probe_unit_assertions.sv
tb_probe_unit.sv

/* Bender.yml */
package:
  name: probe_unit

sources:
  - dcache_pkg.sv
  - probe_intake.sv
  - probe_queue.sv
  - probe_engine.sv
  - probe_unit.sv
  - target: test
    files:
      - probe_unit_assertions.sv
      - tb_probe_unit.sv

/* tb_probe_unit.sv */
// probe unit testbench
module tb_probe_unit;

    localparam int NUM_PROBES = 32;
    localparam int TIMEOUT    = 1000;  // cycles allowed per wait

    logic                                          clk;
    logic                                          rst_n = 1'b0;
    logic                                          tl_b_valid_i = 1'b0;
    dcache_pkg::tl_b_t                             tl_b_i = '0;
    logic                                          tl_b_ready_o;
    logic                                          tl_c_valid_o;
    dcache_pkg::tl_c_t                             tl_c_o;
    logic                                          tl_c_ready_i = 1'b0;
    logic                                          tag_valid_o;
    dcache_pkg::tag_req_t                          tag_req_o;
    dcache_pkg::cache_tag_t [dcache_pkg::WAYS-1:0] tag_rtag_i = '0;
    logic                                          data_valid_o;
    logic [dcache_pkg::WAY_BITS-1:0]               data_way_o;
    logic [dcache_pkg::SET_BITS-1:0]               data_set_o;
    logic [dcache_pkg::LINE_BITS-1:0]              data_rline_i = '0;

    dcache_pkg::cache_tag_t tag_mem [2**dcache_pkg::SET_BITS][dcache_pkg::WAYS];
    logic                            tag_rd_pend = 1'b0;
    logic [dcache_pkg::SET_BITS-1:0] tag_rd_set;
    logic                            data_pend = 1'b0;
    logic [dcache_pkg::WAY_BITS-1:0] data_way_pend;
    logic [dcache_pkg::SET_BITS-1:0] data_set_pend;
    logic [31:0]                     lfsr_q = 32'h06e40347;
    logic                            hold_c = 1'b1;  // withhold C ready
    int                              c_count = 0;

    probe_unit probe_unit_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'h80200003 : lfsr_q >> 1;
            val    = {val[30:0], lfsr_q[0]};
        end
        return val;
    endfunction

    function automatic logic [dcache_pkg::LINE_BITS-1:0] line_pattern(
        input logic [dcache_pkg::SET_BITS-1:0] set_idx,
        input logic [dcache_pkg::WAY_BITS-1:0] way);
        return {{4{set_idx, 6'h15, way}}, {4{~set_idx, 6'h2a, ~way}}};
    endfunction

    // sram models, read data arrives in the cycle after the command
    always @(posedge clk) begin
        tag_rd_pend   <= tag_valid_o && tag_req_o.we == '0;
        tag_rd_set    <= tag_req_o.set;
        data_pend     <= data_valid_o;
        data_way_pend <= data_way_o;
        data_set_pend <= data_set_o;
        if (tag_valid_o) begin
            for (int w = 0; w < dcache_pkg::WAYS; w++) begin
                if (tag_req_o.we[w]) begin
                    tag_mem[tag_req_o.set][w] <= tag_req_o.tag;
                end
            end
        end
        if (rst_n && tl_c_valid_o && tl_c_ready_i) begin
            c_count <= c_count + 1;
        end
    end

    always @(negedge clk) begin
        if (tag_rd_pend) begin
            for (int w = 0; w < dcache_pkg::WAYS; w++) begin
                tag_rtag_i[w] = tag_mem[tag_rd_set][w];
            end
        end
        if (data_pend) begin
            data_rline_i = line_pattern(data_set_pend, data_way_pend);
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // next falling edge, C ready three cycles in four unless held
    task automatic tick();
        @(negedge clk);
        if (probe_unit_inst.checks_inst.error_count != 0) begin
            abort_run("an assertion in probe_unit_assertions failed");
        end
        tl_c_ready_i = !hold_c && next_bits(2) != 0;
    endtask

    task automatic send_beat(input dcache_pkg::tl_b_t beat);
        int waited;
        waited       = 0;
        tl_b_valid_i = 1'b1;
        tl_b_i       = beat;
        while (!tl_b_ready_o) begin
            tick();
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("timeout waiting for tl_b_ready_o");
            end
        end
        tick();  // transfer on the rising edge in between
        tl_b_valid_i = 1'b0;
    endtask

    // one probe per set, either on a preloaded tag or on a tag that cannot match
    task automatic send_probe(input int idx);
        dcache_pkg::tl_b_t               beat;
        logic [dcache_pkg::SET_BITS-1:0] set_idx;
        logic [dcache_pkg::TAG_BITS-1:0] tag;
        set_idx = idx * 37 + 5;
        tag     = next_bits(dcache_pkg::TAG_BITS);
        tag[2]  = 1'b1;  // preloaded tags all have bit 2 clear
        if (next_bits(1) != 0) begin
            tag = tag_mem[set_idx][next_bits(2)].tag;
        end
        beat.opcode  = dcache_pkg::OP_PROBE;
        beat.param   = next_bits(1) != 0 ? dcache_pkg::CAP_TO_B : dcache_pkg::CAP_TO_N;
        beat.size    = dcache_pkg::OFFSET_BITS;
        beat.source  = 1'b0;
        beat.address = {tag, set_idx, 4'(next_bits(4))};
        send_beat(beat);
    endtask

    initial begin
        int                              waited;
        dcache_pkg::tl_b_t               beat;
        logic [dcache_pkg::TAG_BITS-1:0] tag;
        for (int s = 0; s < 2**dcache_pkg::SET_BITS; s++) begin
            for (int w = 0; w < dcache_pkg::WAYS; w++) begin
                tag      = next_bits(dcache_pkg::TAG_BITS);
                tag[2:0] = 3'(w);  // ways of a set never share a tag
                tag_mem[s][w].tag = tag;
                tag_mem[s][w].rp  = next_bits(2) != 0;
                tag_mem[s][w].wp  = tag_mem[s][w].rp && next_bits(1) != 0;
            end
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // C held off until the B channel stalls
        for (int i = 0; i < 5; i++) begin
            send_probe(i);
        end
        waited = 0;
        while (tl_b_ready_o) begin
            tick();
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("tl_b_ready_o never dropped while C was stalled");
            end
        end
        repeat (8) tick();
        hold_c = 1'b0;

        beat         = '0;
        beat.opcode  = 3'd4;  // get, not a probe
        beat.address = 32'h0000_1230;
        send_beat(beat);
        for (int i = 5; i < NUM_PROBES; i++) begin
            send_probe(i);
        end

        waited = 0;
        while (c_count < NUM_PROBES) begin
            tick();
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("timeout waiting for the C responses");
            end
        end
        repeat (20) tick();
        if (probe_unit_inst.checks_inst.error_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            abort_run("an assertion in probe_unit_assertions failed");
        end
    end

endmodule

/* probe_unit_assertions.sv */
// probe unit checker
module probe_unit_assertions (
    input logic                                          clk,
    input logic                                          rst_n,
    input logic                                          tl_b_valid_i,
    input dcache_pkg::tl_b_t                             tl_b_i,
    input logic                                          tl_b_ready_o,
    input logic                                          tl_c_valid_o,
    input dcache_pkg::tl_c_t                             tl_c_o,
    input logic                                          tl_c_ready_i,
    input logic                                          tag_valid_o,
    input dcache_pkg::tag_req_t                          tag_req_o,
    input dcache_pkg::cache_tag_t [dcache_pkg::WAYS-1:0] tag_rtag_i,
    input logic                                          data_valid_o,
    input logic [dcache_pkg::WAY_BITS-1:0]               data_way_o,
    input logic [dcache_pkg::SET_BITS-1:0]               data_set_o,
    input logic [dcache_pkg::LINE_BITS-1:0]              data_rline_i
);

    int unsigned error_count = 0;  // failed assertions so far

    logic [dcache_pkg::LINE_ADDR_BITS-1:0]         line_fifo_q [8];  // probes awaiting a C beat
    logic [7:0]                                    tob_fifo_q;
    logic [2:0]                                    wr_q;
    logic [2:0]                                    rd_q;
    logic [3:0]                                    in_flight_q;
    logic                                          tag_rd_q;
    logic                                          data_rd_q;
    logic                                          line_ok_q;  // line read for the current probe
    logic                                          tag_wr_q;   // tag written for the current probe
    dcache_pkg::cache_tag_t [dcache_pkg::WAYS-1:0] tags_q;
    logic [dcache_pkg::LINE_BITS-1:0]              line_q;
    logic                                          b_probe;
    logic                                          c_fire;
    logic [dcache_pkg::LINE_ADDR_BITS-1:0]         front_line;
    logic                                          front_tob;
    logic [dcache_pkg::SET_BITS-1:0]               front_set;
    logic [dcache_pkg::TAG_BITS-1:0]               front_tag;
    logic                                          exp_hit;
    logic                                          exp_wp;
    logic [dcache_pkg::WAY_BITS-1:0]               exp_way;
    logic [dcache_pkg::WAYS-1:0]                   exp_mask;
    logic [2:0]                                    exp_op;
    logic [2:0]                                    exp_param;
    logic [42:0]                                   c_hdr;
    logic [42:0]                                   exp_hdr;

    assign b_probe    = tl_b_valid_i && tl_b_ready_o && tl_b_i.opcode == dcache_pkg::OP_PROBE;
    assign c_fire     = tl_c_valid_o && tl_c_ready_i;
    assign front_line = line_fifo_q[rd_q];
    assign front_tob  = tob_fifo_q[rd_q];
    assign front_set  = front_line[dcache_pkg::SET_BITS-1:0];
    assign front_tag  = front_line[dcache_pkg::LINE_ADDR_BITS-1:dcache_pkg::SET_BITS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_q        <= '0;
            rd_q        <= '0;
            in_flight_q <= '0;
            tag_rd_q    <= 1'b0;
            data_rd_q   <= 1'b0;
            line_ok_q   <= 1'b0;
            tag_wr_q    <= 1'b0;
        end else begin
            if (b_probe) begin
                line_fifo_q[wr_q] <=
                    tl_b_i.address[dcache_pkg::ADDR_BITS-1:dcache_pkg::OFFSET_BITS];
                tob_fifo_q[wr_q]  <= tl_b_i.param == dcache_pkg::CAP_TO_B;
                wr_q              <= wr_q + 3'd1;
            end
            if (c_fire) begin
                rd_q <= rd_q + 3'd1;
            end
            in_flight_q <= in_flight_q + 4'(b_probe) - 4'(c_fire);
            tag_rd_q    <= tag_valid_o && tag_req_o.we == '0;
            data_rd_q   <= data_valid_o;
            if (tag_rd_q) begin
                tags_q <= tag_rtag_i;  // sram answer to last cycle's read
            end
            if (data_rd_q) begin
                line_q    <= data_rline_i;
                line_ok_q <= 1'b1;
            end else if (c_fire) begin
                line_ok_q <= 1'b0;
            end
            if (tag_valid_o && tag_req_o.we != '0) begin
                tag_wr_q <= 1'b1;
            end else if (c_fire) begin
                tag_wr_q <= 1'b0;
            end
        end
    end

    // expected outcome from the captured tags, first matching way wins
    always_comb begin
        exp_hit = 1'b0;
        exp_way = '0;
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            if (!exp_hit && tags_q[w].rp && tags_q[w].tag == front_tag) begin
                exp_hit = 1'b1;
                exp_way = w[dcache_pkg::WAY_BITS-1:0];
            end
        end
        exp_wp            = exp_hit && tags_q[exp_way].wp;
        exp_mask          = '0;
        exp_mask[exp_way] = 1'b1;
        exp_op            = exp_wp ? dcache_pkg::OP_PROBE_ACK_DATA : dcache_pkg::OP_PROBE_ACK;
        if (exp_wp) begin
            exp_param = front_tob ? dcache_pkg::SHRINK_TTOB : dcache_pkg::SHRINK_TTON;
        end else if (exp_hit) begin
            exp_param = front_tob ? dcache_pkg::SHRINK_BTOB : dcache_pkg::SHRINK_BTON;
        end else begin
            exp_param = dcache_pkg::SHRINK_NTON;
        end
    end

    assign c_hdr   = {tl_c_o.opcode, tl_c_o.param, tl_c_o.size, tl_c_o.source, tl_c_o.address};
    assign exp_hdr = {exp_op, exp_param, 4'(dcache_pkg::OFFSET_BITS), dcache_pkg::SOURCE_ID,
                      front_line, 4'h0};

    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !tl_c_valid_o && !tag_valid_o && !data_valid_o)
        else begin
            $error("a valid output was high during or right after reset");
            error_count++;
        end

    c_stable: assert property (@(posedge clk) disable iff (!rst_n)
        tl_c_valid_o && !tl_c_ready_i |=> tl_c_valid_o && $stable(tl_c_o))
        else begin
            $error("ERROR tl_c_o changed or dropped valid while stalled, now %h",
                   $sampled(tl_c_o));
            error_count++;
        end

    c_header: assert property (@(posedge clk) disable iff (!rst_n)
        c_fire |-> in_flight_q != 0 && c_hdr == exp_hdr)
        else begin
            $error("ERROR tl_c_o header %h expected %h, probes pending %h",
                   $sampled(c_hdr), $sampled(exp_hdr), $sampled(in_flight_q));
            error_count++;
        end

    c_data: assert property (@(posedge clk) disable iff (!rst_n)
        c_fire && tl_c_o.opcode == dcache_pkg::OP_PROBE_ACK_DATA
            |-> line_ok_q && tl_c_o.data == line_q)
        else begin
            $error("ERROR tl_c_o.data %h expected %h", $sampled(tl_c_o.data), $sampled(line_q));
            error_count++;
        end

    // tags must come from the set of the probe in the engine
    tag_read: assert property (@(posedge clk) disable iff (!rst_n)
        tag_valid_o && tag_req_o.we == '0 |-> tag_req_o.set == front_set)
        else begin
            $error("ERROR tag_req_o.set %h expected %h",
                   $sampled(tag_req_o.set), $sampled(front_set));
            error_count++;
        end

    data_read: assert property (@(posedge clk) disable iff (!rst_n)
        data_valid_o |-> exp_wp && data_way_o == exp_way && data_set_o == front_set)
        else begin
            $error("ERROR data_way_o %h data_set_o %h expected way %h set %h",
                   $sampled(data_way_o), $sampled(data_set_o),
                   $sampled(exp_way), $sampled(front_set));
            error_count++;
        end

    tag_write: assert property (@(posedge clk) disable iff (!rst_n)
        tag_valid_o && tag_req_o.we != '0 |-> exp_hit && tag_req_o.we == exp_mask
            && tag_req_o.set == front_set && tag_req_o.tag == {front_tag, front_tob, 1'b0})
        else begin
            $error("ERROR tag_req_o %h expected mask %h entry %h", $sampled(tag_req_o),
                   $sampled(exp_mask), $sampled({front_tag, front_tob, 1'b0}));
            error_count++;
        end

    // every hit downgrades its way before the answer goes out
    hit_updates: assert property (@(posedge clk) disable iff (!rst_n)
        c_fire |-> tag_wr_q == exp_hit)
        else begin
            $error("a probe was answered without the tag write its hit or miss calls for");
            error_count++;
        end

    // four queued plus one in the engine is the limit
    b_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
        in_flight_q >= 4'd5 |-> !tl_b_ready_o)
        else begin
            $error("tl_b_ready_o stayed high with five probes in flight");
            error_count++;
        end

endmodule

bind probe_unit probe_unit_assertions checks_inst (.*);

/* probe_unit.sv */
// dcache probe unit top
module probe_unit (
    input  logic                                         clk,
    input  logic                                         rst_n,
    // tilelink b
    input  logic                                         tl_b_valid_i,
    input  dcache_pkg::tl_b_t                            tl_b_i,
    output logic                                         tl_b_ready_o,
    // tilelink c
    output logic                                         tl_c_valid_o,
    output dcache_pkg::tl_c_t                            tl_c_o,
    input  logic                                         tl_c_ready_i,
    // tag sram
    output logic                                         tag_valid_o,
    output dcache_pkg::tag_req_t                         tag_req_o,
    input  dcache_pkg::cache_tag_t [dcache_pkg::WAYS-1:0] tag_rtag_i,
    // data sram
    output logic                                         data_valid_o,
    output logic [dcache_pkg::WAY_BITS-1:0]              data_way_o,
    output logic [dcache_pkg::SET_BITS-1:0]              data_set_o,
    input  logic [dcache_pkg::LINE_BITS-1:0]             data_rline_i
);

    logic                   push_valid;
    logic                   push_ready;
    dcache_pkg::probe_req_t push_req;
    logic                   pop_valid;
    logic                   pop_ready;
    dcache_pkg::probe_req_t pop_req;

    probe_intake intake_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .tl_b_valid_i (tl_b_valid_i),
        .tl_b_i       (tl_b_i),
        .tl_b_ready_o (tl_b_ready_o),
        .push_valid_o (push_valid),
        .push_req_o   (push_req),
        .push_ready_i (push_ready)
    );

    probe_queue queue_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .push_valid_i (push_valid),
        .push_req_i   (push_req),
        .push_ready_o (push_ready),
        .pop_valid_o  (pop_valid),
        .pop_req_o    (pop_req),
        .pop_ready_i  (pop_ready)
    );

    probe_engine engine_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .pop_valid_i  (pop_valid),
        .pop_req_i    (pop_req),
        .pop_ready_o  (pop_ready),
        .tag_valid_o  (tag_valid_o),
        .tag_req_o    (tag_req_o),
        .tag_rtag_i   (tag_rtag_i),
        .data_valid_o (data_valid_o),
        .data_way_o   (data_way_o),
        .data_set_o   (data_set_o),
        .data_rline_i (data_rline_i),
        .tl_c_valid_o (tl_c_valid_o),
        .tl_c_o       (tl_c_o),
        .tl_c_ready_i (tl_c_ready_i)
    );

endmodule

/* probe_engine.sv */
// probe lookup and response fsm
module probe_engine (
    input  logic                                         clk,
    input  logic                                         rst_n,
    // queue pop side
    input  logic                                         pop_valid_i,
    input  dcache_pkg::probe_req_t                       pop_req_i,
    output logic                                         pop_ready_o,
    // tag sram
    output logic                                         tag_valid_o,
    output dcache_pkg::tag_req_t                         tag_req_o,
    input  dcache_pkg::cache_tag_t [dcache_pkg::WAYS-1:0] tag_rtag_i,
    // data sram, reads only
    output logic                                         data_valid_o,
    output logic [dcache_pkg::WAY_BITS-1:0]              data_way_o,
    output logic [dcache_pkg::SET_BITS-1:0]              data_set_o,
    input  logic [dcache_pkg::LINE_BITS-1:0]             data_rline_i,
    // tilelink c
    output logic                                         tl_c_valid_o,
    output dcache_pkg::tl_c_t                            tl_c_o,
    input  logic                                         tl_c_ready_i
);

    typedef enum logic [2:0] {
        S_FREE,
        S_TAG_RD,
        S_HIT_SEL,
        S_TAG_WR,
        S_DATA_RD,
        S_DATA_CAP,
        S_C_ISSUE
    } state_e;

    state_e                              state_q;
    state_e                              state_d;
    dcache_pkg::probe_req_t              req_q;
    logic                                hit_q;
    logic                                rp_q;
    logic                                wp_q;
    logic [dcache_pkg::WAY_BITS-1:0]     way_q;
    logic [dcache_pkg::LINE_BITS-1:0]    line_q;

    logic [dcache_pkg::SET_BITS-1:0]     req_set;
    logic [dcache_pkg::TAG_BITS-1:0]     req_tag;
    logic                                hit_any;
    logic [dcache_pkg::WAY_BITS-1:0]     hit_way;
    logic                                has_data;

    assign req_set  = req_q.line_addr[dcache_pkg::SET_BITS-1:0];
    assign req_tag  = req_q.line_addr[dcache_pkg::LINE_ADDR_BITS-1:dcache_pkg::SET_BITS];
    assign has_data = hit_q && wp_q;  // dirty owner sends the line back

    // tag compare, lowest way wins on multiple matches
    always_comb begin
        hit_any = 1'b0;
        hit_way = '0;
        for (int w = dcache_pkg::WAYS - 1; w >= 0; w--) begin
            if (tag_rtag_i[w].rp && tag_rtag_i[w].tag == req_tag) begin
                hit_any = 1'b1;
                hit_way = w[dcache_pkg::WAY_BITS-1:0];
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_FREE: begin
                if (pop_valid_i) begin
                    state_d = S_TAG_RD;
                end
            end
            S_TAG_RD:   state_d = S_HIT_SEL;
            S_HIT_SEL:  state_d = hit_any ? S_TAG_WR : S_C_ISSUE;  // miss skips the update
            S_TAG_WR:   state_d = wp_q ? S_DATA_RD : S_C_ISSUE;
            S_DATA_RD:  state_d = S_DATA_CAP;
            S_DATA_CAP: state_d = S_C_ISSUE;
            S_C_ISSUE: begin
                if (tl_c_ready_i) begin
                    state_d = S_FREE;
                end
            end
            default:    state_d = S_FREE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_FREE;
            hit_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == S_HIT_SEL) begin
                hit_q <= hit_any;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop_valid_i && pop_ready_o) begin
            req_q <= pop_req_i;
        end
        if (state_q == S_HIT_SEL) begin
            way_q <= hit_way;
            rp_q  <= tag_rtag_i[hit_way].rp;
            wp_q  <= tag_rtag_i[hit_way].wp;
        end
        if (state_q == S_DATA_CAP) begin
            line_q <= data_rline_i;  // sram line from last cycle's read
        end
    end

    assign pop_ready_o = state_q == S_FREE;

    // tag port, read in S_TAG_RD, downgrade in S_TAG_WR
    assign tag_valid_o = (state_q == S_TAG_RD) || (state_q == S_TAG_WR);
    always_comb begin
        tag_req_o.set = req_set;
        tag_req_o.we  = '0;
        if (state_q == S_TAG_WR) begin
            tag_req_o.we[way_q] = 1'b1;
        end
        tag_req_o.tag.tag = req_tag;
        tag_req_o.tag.rp  = req_q.to_b;  // toB keeps read, toN drops it
        tag_req_o.tag.wp  = 1'b0;
    end

    assign data_valid_o = state_q == S_DATA_RD;
    assign data_way_o   = way_q;
    assign data_set_o   = req_set;

    assign tl_c_valid_o = state_q == S_C_ISSUE;
    always_comb begin
        tl_c_o.opcode = has_data ? dcache_pkg::OP_PROBE_ACK_DATA : dcache_pkg::OP_PROBE_ACK;
        if (hit_q && wp_q) begin
            tl_c_o.param = req_q.to_b ? dcache_pkg::SHRINK_TTOB : dcache_pkg::SHRINK_TTON;
        end else if (hit_q && rp_q) begin
            tl_c_o.param = req_q.to_b ? dcache_pkg::SHRINK_BTOB : dcache_pkg::SHRINK_BTON;
        end else begin
            tl_c_o.param = dcache_pkg::SHRINK_NTON;
        end
        tl_c_o.size    = dcache_pkg::OFFSET_BITS[dcache_pkg::SIZE_BITS-1:0];
        tl_c_o.source  = dcache_pkg::SOURCE_ID;
        tl_c_o.address = {req_q.line_addr, {dcache_pkg::OFFSET_BITS{1'b0}}};
        tl_c_o.data    = has_data ? line_q : '0;
    end

endmodule

/* probe_queue.sv */
// probe request fifo
module probe_queue (
    input  logic                   clk,
    input  logic                   rst_n,
    // push side
    input  logic                   push_valid_i,
    input  dcache_pkg::probe_req_t push_req_i,
    output logic                   push_ready_o,
    // pop side
    output logic                   pop_valid_o,
    output dcache_pkg::probe_req_t pop_req_o,
    input  logic                   pop_ready_i
);

    dcache_pkg::probe_req_t                entries_q [dcache_pkg::QUEUE_DEPTH];
    logic [dcache_pkg::QUEUE_PTR_BITS-1:0] wr_ptr_q;
    logic [dcache_pkg::QUEUE_PTR_BITS-1:0] rd_ptr_q;
    logic [dcache_pkg::QUEUE_PTR_BITS:0]   count_q;  // occupancy
    logic                                  push;
    logic                                  pop;

    assign push_ready_o = count_q != (dcache_pkg::QUEUE_PTR_BITS + 1)'(dcache_pkg::QUEUE_DEPTH);
    assign pop_valid_o  = count_q != '0;
    assign pop_req_o    = entries_q[rd_ptr_q];

    assign push = push_valid_i && push_ready_o;
    assign pop  = pop_valid_o && pop_ready_i;

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10: begin
                    count_q <= count_q + 1'b1;
                end
                2'b01: begin
                    count_q <= count_q - 1'b1;
                end
                default: begin
                    count_q <= count_q;  // idle or push and pop together
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries_q[wr_ptr_q] <= push_req_i;
        end
    end

endmodule

/* probe_intake.sv */
// b channel probe intake
module probe_intake (
    input  logic                   clk,
    input  logic                   rst_n,
    // tilelink b
    input  logic                   tl_b_valid_i,
    input  dcache_pkg::tl_b_t      tl_b_i,
    output logic                   tl_b_ready_o,
    // queue push side
    output logic                   push_valid_o,
    output dcache_pkg::probe_req_t push_req_o,
    input  logic                   push_ready_i
);

    logic       is_probe;
    logic [7:0] drop_cnt_q;  // non-probe beats thrown away

    assign is_probe     = tl_b_i.opcode == dcache_pkg::OP_PROBE;
    assign tl_b_ready_o = push_ready_i;             // full queue stalls the bus
    assign push_valid_o = tl_b_valid_i && is_probe;

    always_comb begin
        // strip the byte offset
        push_req_o.line_addr = tl_b_i.address[dcache_pkg::ADDR_BITS-1:dcache_pkg::OFFSET_BITS];
        case (tl_b_i.param)
            dcache_pkg::CAP_TO_B: begin
                push_req_o.to_b = 1'b1;
            end
            dcache_pkg::CAP_TO_N: begin
                push_req_o.to_b = 1'b0;
            end
            default: begin
                push_req_o.to_b = 1'b0;  // toT treated as invalidate
            end
        endcase
    end

    // beats with other opcodes are taken and dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drop_cnt_q <= '0;
        end else if (tl_b_valid_i && tl_b_ready_o && !is_probe) begin
            drop_cnt_q <= drop_cnt_q + 8'd1;
        end
    end

endmodule

/* dcache_pkg.sv */
// dcache probe path definitions
package dcache_pkg;

    // cache geometry
    localparam int ADDR_BITS      = 32;
    localparam int LINE_BITS      = 128;
    localparam int WAYS           = 4;
    localparam int WAY_BITS       = $clog2(WAYS);
    localparam int SET_BITS       = 8;    // address bits 11:4
    localparam int OFFSET_BITS    = 4;    // also the tl size code of a full line
    localparam int TAG_BITS       = 20;   // address bits 31:12
    localparam int LINE_ADDR_BITS = ADDR_BITS - OFFSET_BITS;
    localparam int SIZE_BITS      = 4;

    localparam int QUEUE_DEPTH    = 4;
    localparam int QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);

    localparam logic SOURCE_ID = 1'b0;    // our c channel source

    // tilelink opcodes
    localparam logic [2:0] OP_PROBE          = 3'd6;  // b channel
    localparam logic [2:0] OP_PROBE_ACK      = 3'd4;  // c channel
    localparam logic [2:0] OP_PROBE_ACK_DATA = 3'd5;

    // cap params on b
    localparam logic [2:0] CAP_TO_B = 3'd1;
    localparam logic [2:0] CAP_TO_N = 3'd2;

    // shrink / report params on c
    localparam logic [2:0] SHRINK_TTOB = 3'd0;
    localparam logic [2:0] SHRINK_TTON = 3'd1;
    localparam logic [2:0] SHRINK_BTON = 3'd2;
    localparam logic [2:0] SHRINK_BTOB = 3'd4;
    localparam logic [2:0] SHRINK_NTON = 3'd5;

    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic                rp;  // read permission
        logic                wp;  // write permission
    } cache_tag_t;

    typedef struct packed {
        logic [2:0]           opcode;
        logic [2:0]           param;
        logic [SIZE_BITS-1:0] size;
        logic                 source;
        logic [ADDR_BITS-1:0] address;
    } tl_b_t;

    typedef struct packed {
        logic [2:0]           opcode;
        logic [2:0]           param;
        logic [SIZE_BITS-1:0] size;
        logic                 source;
        logic [ADDR_BITS-1:0] address;
        logic [LINE_BITS-1:0] data;
    } tl_c_t;

    // one queued probe
    typedef struct packed {
        logic [LINE_ADDR_BITS-1:0] line_addr;
        logic                      to_b;  // keep read permission
    } probe_req_t;

    // tag sram command, we == 0 is a read
    typedef struct packed {
        logic [SET_BITS-1:0] set;
        logic [WAYS-1:0]     we;
        cache_tag_t          tag;
    } tag_req_t;

endpackage
